// File: mbox_defs.svh
//--------------------------------------------------------------------------
// Mailbox build constants
// FIFO depth, bus data width and register offset width shared by the
// packages and the RTL modules
//--------------------------------------------------------------------------

`ifndef MBOX_DEFS_SVH
`define MBOX_DEFS_SVH

// words held by each direction's FIFO
`define MBOX_DEPTH 8

// register and bus data width in bits
`define MBOX_DATA_W 32

// word offset width, register index sits in bits 5:2
`define MBOX_OFFS_W 6

`endif

// File: mbox_bus_pkg.sv
//--------------------------------------------------------------------------
// Mailbox bus package
// AXI4-Lite channel types and response codes for one register port
//--------------------------------------------------------------------------

`include "mbox_defs.svh"

package mbox_bus_pkg;

  typedef logic [`MBOX_OFFS_W-1:0] addr_t;  // word offset within a port
  typedef logic [`MBOX_DATA_W-1:0] data_t;  // full-word data, no strobes

  // only two codes ever used on this slave
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // master to slave, AW and W must come together
  typedef struct packed {
    addr_t aw_addr;
    data_t w_data;
    logic  aw_valid;
    logic  w_valid;
    logic  b_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  r_ready;
  } req_t;

  // slave to master
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  b_valid;
    resp_e b_resp;
    logic  ar_ready;
    logic  r_valid;
    data_t r_data;
    resp_e r_resp;
  } rsp_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;   // write response payload

  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_chan_t;   // read response payload

endpackage

// File: mbox_reg_pkg.sv
//--------------------------------------------------------------------------
// Mailbox register package
// register map, status and interrupt bit layouts, the write-data views
// and the fixed read words of the mailbox port
//--------------------------------------------------------------------------

`include "mbox_defs.svh"

package mbox_reg_pkg;

  // register index, taken from address bits 5:2
  typedef enum logic [3:0] {
    MBOXW  = 4'd0,  // push a word to the peer
    MBOXR  = 4'd1,  // pop a word from the peer
    STATUS = 4'd2,
    ERROR  = 4'd3,  // clear on read
    WIRQT  = 4'd4,  // write fill threshold
    RIRQT  = 4'd5,  // read fill threshold
    IRQS   = 4'd6,  // write one to clear
    IRQEN  = 4'd7,
    IRQP   = 4'd8,  // status and enable
    CTRL   = 4'd9   // flush strobes
  } reg_e;

  // fill count, one bit wider so a full FIFO is representable
  typedef logic [$clog2(`MBOX_DEPTH):0] usage_t;

  typedef struct packed {
    logic err;  // bus error seen
    logic rd;   // read fill above RIRQT
    logic wr;   // write fill above WIRQT
  } irq_bits_t;

  typedef struct packed {
    logic rd_thr;
    logic wr_thr;
    logic wr_full;
    logic rd_empty;
  } status_t;

  // low bits of a written word as irq bits, bit 1/0 double as flush read/write
  typedef struct packed {
    logic [`MBOX_DATA_W-4:0] pad;
    irq_bits_t               irq;
  } ctrl_view_t;

  typedef union packed {
    logic [`MBOX_DATA_W-1:0] raw;   // thresholds
    ctrl_view_t              ctrl;  // IRQS, IRQEN, CTRL
  } wdata_u;

  localparam logic [`MBOX_DATA_W-1:0] MBOXW_READ_WORD = 'hFEEDC0DE;
  localparam logic [`MBOX_DATA_W-1:0] EMPTY_READ_WORD = 'hFEEDDEAD;

endpackage

// File: mbox_fifo.sv
//--------------------------------------------------------------------------
// Mailbox FIFO
// one direction of the mailbox, circular buffer with fill count and a
// flush that empties it in one cycle
//--------------------------------------------------------------------------

`include "mbox_defs.svh"

module mbox_fifo (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,   // drop all words, beats push
  input  logic                 push_i,
  input  mbox_bus_pkg::data_t  data_i,
  input  logic                 pop_i,
  output mbox_bus_pkg::data_t  data_o,    // head word, registered storage
  output logic                 full_o,
  output logic                 empty_o,
  output mbox_reg_pkg::usage_t usage_o
);

  localparam int unsigned PtrW = ($clog2(`MBOX_DEPTH) > 0) ? $clog2(`MBOX_DEPTH) : 1;

  mbox_bus_pkg::data_t  mem_q [`MBOX_DEPTH];
  logic [PtrW-1:0]      wr_ptr_q, rd_ptr_q;
  mbox_reg_pkg::usage_t cnt_q;

  assign data_o  = mem_q[rd_ptr_q];  // no fall-through
  assign full_o  = (cnt_q == mbox_reg_pkg::usage_t'(`MBOX_DEPTH));
  assign empty_o = (cnt_q == '0);
  assign usage_o = cnt_q;

  // pointers and count
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(`MBOX_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(`MBOX_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // idle or both at once
      endcase
    end
  end

  // storage, payload only
  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) mem_q[wr_ptr_q] <= data_i;
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_o)
    else $error("push into full mailbox FIFO");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_o)
    else $error("pop from empty mailbox FIFO");

endmodule

// File: mbox_resp_stage.sv
//--------------------------------------------------------------------------
// Response holding stage
// one-entry register for a B or R payload, cuts the path from the
// register logic to the bus outputs
//--------------------------------------------------------------------------

module mbox_resp_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // free when empty or drained this cycle
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) data_q <= data_i;  // load on handshake only
  end

  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("response changed under back-pressure");

endmodule

// File: mbox_port.sv
//--------------------------------------------------------------------------
// Mailbox port
// AXI4-Lite register slave for one side: decodes the word offset, holds
// error, threshold and irq registers, pushes to the outgoing FIFO and
// pops from the incoming one. B and R leave through holding stages
//--------------------------------------------------------------------------

`include "mbox_defs.svh"

module mbox_port (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  mbox_bus_pkg::req_t   bus_req_i,
  output mbox_bus_pkg::rsp_t   bus_rsp_o,
  // outgoing FIFO
  output logic                 w_push_o,
  output mbox_bus_pkg::data_t  w_data_o,
  output logic                 w_flush_o,
  input  logic                 w_full_i,
  input  mbox_reg_pkg::usage_t w_usage_i,
  // incoming FIFO
  output logic                 r_pop_o,
  output logic                 r_flush_o,
  input  mbox_bus_pkg::data_t  r_data_i,
  input  logic                 r_empty_i,
  input  mbox_reg_pkg::usage_t r_usage_i,
  output logic                 irq_o       // level, active high
);

  mbox_reg_pkg::reg_e      w_idx, r_idx;    // decoded offsets
  mbox_reg_pkg::wdata_u    w_word;
  logic                    w_req, b_ready, w_acc;
  logic                    r_ready, r_acc;
  mbox_bus_pkg::b_chan_t   b_chan, b_out;
  mbox_bus_pkg::r_chan_t   r_chan, r_out;
  logic [1:0]              error_q, error_d;  // bit 1 write-full, bit 0 read-empty
  mbox_reg_pkg::usage_t    wirqt_q, wirqt_d, rirqt_q, rirqt_d;
  mbox_reg_pkg::irq_bits_t irqs_q, irqs_d, irqen_q, irqen_d;
  mbox_reg_pkg::irq_bits_t irqp, irqs_clr, irqs_set;
  mbox_reg_pkg::status_t   status;
  logic                    rd_err, wr_err, err_clr;

  // thresholds saturate one below depth so a full FIFO still fires
  function automatic mbox_reg_pkg::usage_t clamp_thr(mbox_bus_pkg::data_t v);
    if (v >= `MBOX_DEPTH) return mbox_reg_pkg::usage_t'(`MBOX_DEPTH - 1);
    return mbox_reg_pkg::usage_t'(v);
  endfunction

  assign w_idx  = mbox_reg_pkg::reg_e'(bus_req_i.aw_addr[`MBOX_OFFS_W-1:2]);
  assign r_idx  = mbox_reg_pkg::reg_e'(bus_req_i.ar_addr[`MBOX_OFFS_W-1:2]);
  assign w_word = bus_req_i.w_data;
  assign w_data_o = w_word.raw;

  assign w_req = bus_req_i.aw_valid && bus_req_i.w_valid;  // AW and W together
  assign w_acc = w_req && b_ready;
  assign r_acc = bus_req_i.ar_valid && r_ready;

  assign status.rd_thr   = (r_usage_i > rirqt_q);
  assign status.wr_thr   = (w_usage_i > wirqt_q);
  assign status.wr_full  = w_full_i;
  assign status.rd_empty = r_empty_i;

  assign irqp  = irqs_q & irqen_q;
  assign irq_o = |irqp;

  //------------------------------------------------------------------------
  // write channel
  //------------------------------------------------------------------------
  always_comb begin
    b_chan.resp = mbox_bus_pkg::RESP_SLVERR;  // read-only and unmapped
    w_push_o    = 1'b0;
    w_flush_o   = 1'b0;
    r_flush_o   = 1'b0;
    wr_err      = 1'b0;
    irqs_clr    = '0;
    wirqt_d     = wirqt_q;
    rirqt_d     = rirqt_q;
    irqen_d     = irqen_q;
    if (w_acc) begin
      case (w_idx)
        mbox_reg_pkg::MBOXW: begin
          if (!w_full_i) begin
            w_push_o    = 1'b1;
            b_chan.resp = mbox_bus_pkg::RESP_OKAY;
          end else begin
            wr_err = 1'b1;  // word dropped
          end
        end
        mbox_reg_pkg::WIRQT: begin
          wirqt_d     = clamp_thr(w_word.raw);
          b_chan.resp = mbox_bus_pkg::RESP_OKAY;
        end
        mbox_reg_pkg::RIRQT: begin
          rirqt_d     = clamp_thr(w_word.raw);
          b_chan.resp = mbox_bus_pkg::RESP_OKAY;
        end
        mbox_reg_pkg::IRQS: begin
          irqs_clr    = w_word.ctrl.irq;  // ones acknowledge
          b_chan.resp = mbox_bus_pkg::RESP_OKAY;
        end
        mbox_reg_pkg::IRQEN: begin
          irqen_d     = w_word.ctrl.irq;
          b_chan.resp = mbox_bus_pkg::RESP_OKAY;
        end
        mbox_reg_pkg::CTRL: begin
          r_flush_o   = w_word.ctrl.irq.rd;  // bit 1
          w_flush_o   = w_word.ctrl.irq.wr;  // bit 0
          b_chan.resp = mbox_bus_pkg::RESP_OKAY;
        end
        default: ;
      endcase
    end
  end

  //------------------------------------------------------------------------
  // read channel
  //------------------------------------------------------------------------
  always_comb begin
    r_chan.data = '0;
    r_chan.resp = mbox_bus_pkg::RESP_OKAY;
    r_pop_o     = 1'b0;
    rd_err      = 1'b0;
    err_clr     = 1'b0;
    case (r_idx)
      mbox_reg_pkg::MBOXW:  r_chan.data = mbox_reg_pkg::MBOXW_READ_WORD;
      mbox_reg_pkg::MBOXR: begin
        if (!r_empty_i) begin
          r_chan.data = r_data_i;
          r_pop_o     = r_acc;  // pop only on handshake
        end else begin
          r_chan.data = mbox_reg_pkg::EMPTY_READ_WORD;
          r_chan.resp = mbox_bus_pkg::RESP_SLVERR;
          rd_err      = r_acc;
        end
      end
      mbox_reg_pkg::STATUS: r_chan.data = mbox_bus_pkg::data_t'(status);
      mbox_reg_pkg::ERROR: begin
        r_chan.data = mbox_bus_pkg::data_t'(error_q);
        err_clr     = r_acc;
      end
      mbox_reg_pkg::WIRQT:  r_chan.data = mbox_bus_pkg::data_t'(wirqt_q);
      mbox_reg_pkg::RIRQT:  r_chan.data = mbox_bus_pkg::data_t'(rirqt_q);
      mbox_reg_pkg::IRQS:   r_chan.data = mbox_bus_pkg::data_t'(irqs_q);
      mbox_reg_pkg::IRQEN:  r_chan.data = mbox_bus_pkg::data_t'(irqen_q);
      mbox_reg_pkg::IRQP:   r_chan.data = mbox_bus_pkg::data_t'(irqp);
      mbox_reg_pkg::CTRL:   r_chan.data = mbox_bus_pkg::data_t'({r_flush_o, w_flush_o});
      default:              r_chan.resp = mbox_bus_pkg::RESP_SLVERR;  // zero data
    endcase
  end

  // clears first, then new events so a fresh error survives
  assign irqs_set.err = rd_err || wr_err;
  assign irqs_set.rd  = status.rd_thr;
  assign irqs_set.wr  = status.wr_thr;
  assign irqs_d  = (irqs_q & ~irqs_clr) | irqs_set;
  assign error_d = (err_clr ? 2'b00 : error_q) | {wr_err, rd_err};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      error_q <= '0;
      wirqt_q <= '0;
      rirqt_q <= '0;
      irqs_q  <= '0;
      irqen_q <= '0;
    end else begin
      error_q <= error_d;
      wirqt_q <= wirqt_d;
      rirqt_q <= rirqt_d;
      irqs_q  <= irqs_d;
      irqen_q <= irqen_d;
    end
  end

  mbox_resp_stage #(.payload_t(mbox_bus_pkg::b_chan_t)) i_b_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (w_req),
    .ready_o (b_ready),
    .data_i  (b_chan),
    .valid_o (bus_rsp_o.b_valid),
    .ready_i (bus_req_i.b_ready),
    .data_o  (b_out)
  );

  mbox_resp_stage #(.payload_t(mbox_bus_pkg::r_chan_t)) i_r_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (bus_req_i.ar_valid),
    .ready_o (r_ready),
    .data_i  (r_chan),
    .valid_o (bus_rsp_o.r_valid),
    .ready_i (bus_req_i.r_ready),
    .data_o  (r_out)
  );

  assign bus_rsp_o.aw_ready = w_acc;  // AW and W accepted in one beat
  assign bus_rsp_o.w_ready  = w_acc;
  assign bus_rsp_o.b_resp   = b_out.resp;
  assign bus_rsp_o.ar_ready = r_acc;
  assign bus_rsp_o.r_data   = r_out.data;
  assign bus_rsp_o.r_resp   = r_out.resp;

  // pop decision is here, empty comes from the peer's FIFO
  a_pop_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    !(r_pop_o && r_empty_i))
    else $error("mailbox pop while incoming FIFO empty");

endmodule

// File: lite_mailbox.sv
//--------------------------------------------------------------------------
// Dual-port AXI4-Lite mailbox
// two register ports, each pushing into its own FIFO and popping from
// the FIFO of the other side, one level irq per port
//--------------------------------------------------------------------------

module lite_mailbox (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  mbox_bus_pkg::req_t [1:0] bus_req_i,
  output mbox_bus_pkg::rsp_t [1:0] bus_rsp_o,
  output logic               [1:0] irq_o
);

  // FIFO i is written by port i and read by port 1-i
  logic                       [1:0] push, pop;     // push by writer, pop by reader
  logic                       [1:0] w_flush, r_flush;
  logic                       [1:0] full, empty;   // index is the FIFO
  mbox_bus_pkg::data_t        [1:0] w_data, head;
  mbox_reg_pkg::usage_t       [1:0] usage;

  for (genvar i = 0; i < 2; i++) begin : gen_port
    mbox_port i_port (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .bus_req_i (bus_req_i[i]),
      .bus_rsp_o (bus_rsp_o[i]),
      .w_push_o  (push[i]),
      .w_data_o  (w_data[i]),
      .w_flush_o (w_flush[i]),
      .w_full_i  (full[i]),
      .w_usage_i (usage[i]),
      .r_pop_o   (pop[i]),
      .r_flush_o (r_flush[i]),
      .r_data_i  (head[1-i]),    // crossed
      .r_empty_i (empty[1-i]),
      .r_usage_i (usage[1-i]),
      .irq_o     (irq_o[i])
    );
  end

  for (genvar i = 0; i < 2; i++) begin : gen_fifo
    mbox_fifo i_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .flush_i (w_flush[i] | r_flush[1-i]),  // either end may flush
      .push_i  (push[i]),
      .data_i  (w_data[i]),
      .pop_i   (pop[1-i]),
      .data_o  (head[i]),
      .full_o  (full[i]),
      .empty_o (empty[i]),
      .usage_o (usage[i])
    );
  end

endmodule

// File: tb_lite_mailbox.sv
//--------------------------------------------------------------------------
// Mailbox testbench
// drives both AXI4-Lite ports with random back-pressure and checks every
// response against a register and FIFO model kept in the testbench
//--------------------------------------------------------------------------

`include "mbox_defs.svh"

module tb_lite_mailbox;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod    = 100;
  localparam int Depth        = `MBOX_DEPTH;
  localparam int NumWords     = 32;  // random data path accesses
  localparam int NumThrRounds = 4;
  localparam int NumRandom    = 40;  // illegal accesses
  localparam int PlannedAccesses = 14 + NumWords + 2 * (Depth + 3) + (2 * Depth + 4)
                                 + NumThrRounds * 32 + 2 * (Depth + 5) + NumRandom + 14;
  localparam logic [1:0] Okay   = 2'b00;
  localparam logic [1:0] SlvErr = 2'b10;

  logic                     clk_i = 1'b0;
  logic                     rst_i;
  mbox_bus_pkg::req_t [1:0] bus_req;
  mbox_bus_pkg::rsp_t [1:0] bus_rsp;
  logic               [1:0] irq;

  // fifo_m[i] models the FIFO written by port i
  logic [31:0] fifo_m [2][$];
  logic [1:0]  err_m [2];    // bit 1 is write-full and bit 0 read-empty
  int          wthr_m [2];
  int          rthr_m [2];
  logic [2:0]  irqs_m [2];   // err, rd, wr
  logic [2:0]  irqen_m [2];

  int errors, checks, tests, errs_at_start;
  int side, cnt, sel;

  lite_mailbox lite_mailbox_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .irq_o     (irq)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  function automatic logic random_ready();
    return ($urandom_range(0, 2) != 0);  // low about one cycle in three
  endfunction

  function automatic logic model_irq(input int p);
    return |(irqs_m[p] & irqen_m[p]);
  endfunction

  // sticky threshold bits are set whenever a fill count sits above its threshold
  task automatic refresh_irq();
    for (int p = 0; p < 2; p++) begin
      if (fifo_m[p].size() > wthr_m[p]) irqs_m[p][0] = 1'b1;
      if (fifo_m[1 - p].size() > rthr_m[p]) irqs_m[p][1] = 1'b1;
    end
  endtask

  //------------------------------------------------------------------------
  // register model
  //------------------------------------------------------------------------
  task automatic model_write(input int p, input int idx, input logic [31:0] d,
                             output logic [1:0] resp);
    resp = SlvErr;                                       // read-only and unmapped
    case (idx)
      0: begin
        if (fifo_m[p].size() < Depth) begin
          fifo_m[p].push_back(d);
          resp = Okay;
        end else begin
          err_m[p][1]  = 1'b1;                           // word lost
          irqs_m[p][2] = 1'b1;
        end
      end
      4: begin
        wthr_m[p] = (d >= Depth) ? Depth - 1 : int'(d);  // clamp
        resp = Okay;
      end
      5: begin
        rthr_m[p] = (d >= Depth) ? Depth - 1 : int'(d);
        resp = Okay;
      end
      6: begin
        irqs_m[p] = irqs_m[p] & ~d[2:0];                 // write one to clear
        resp = Okay;
      end
      7: begin
        irqen_m[p] = d[2:0];
        resp = Okay;
      end
      9: begin
        if (d[0]) fifo_m[p].delete();                    // outgoing
        if (d[1]) fifo_m[1 - p].delete();                // incoming
        resp = Okay;
      end
      default: ;
    endcase
    refresh_irq();
  endtask

  task automatic model_read(input int p, input int idx, output logic [31:0] d,
                            output logic [1:0] resp);
    int q;
    q    = 1 - p;
    d    = '0;
    resp = Okay;
    case (idx)
      0: d = 32'hFEEDC0DE;
      1: begin
        if (fifo_m[q].size() > 0) begin
          d = fifo_m[q].pop_front();
        end else begin
          d            = 32'hFEEDDEAD;
          resp         = SlvErr;
          err_m[p][0]  = 1'b1;
          irqs_m[p][2] = 1'b1;
        end
      end
      2: d = {28'b0, fifo_m[q].size() > rthr_m[p], fifo_m[p].size() > wthr_m[p],
              fifo_m[p].size() == Depth, fifo_m[q].size() == 0};
      3: begin
        d        = {30'b0, err_m[p]};
        err_m[p] = '0;                                   // clear on read
      end
      4: d = 32'(wthr_m[p]);
      5: d = 32'(rthr_m[p]);
      6: d = {29'b0, irqs_m[p]};
      7: d = {29'b0, irqen_m[p]};
      8: d = {29'b0, irqs_m[p] & irqen_m[p]};
      9: d = '0;                                         // flush strobes idle
      default: resp = SlvErr;
    endcase
    refresh_irq();
  endtask

  //------------------------------------------------------------------------
  // bus tasks start and end 5 ns after a rising edge
  //------------------------------------------------------------------------
  task automatic bus_write(input int p, input int idx, input logic [31:0] data,
                           output logic [1:0] resp);
    logic done;
    bus_req[p].aw_addr  = {idx[3:0], 2'b00};
    bus_req[p].w_data   = data;
    bus_req[p].aw_valid = 1'b1;
    bus_req[p].w_valid  = 1'b1;
    bus_req[p].b_ready  = random_ready();
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = bus_rsp[p].aw_ready && bus_rsp[p].w_ready;
      @(posedge clk_i);
      #5;
      bus_req[p].b_ready = random_ready();
    end
    bus_req[p].aw_valid = 1'b0;
    bus_req[p].w_valid  = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = bus_rsp[p].b_valid && bus_req[p].b_ready;
      resp = bus_rsp[p].b_resp;
      @(posedge clk_i);
      #5;
      bus_req[p].b_ready = random_ready();
    end
    bus_req[p].b_ready = 1'b0;
  endtask

  task automatic bus_read(input int p, input int idx, output logic [31:0] data,
                          output logic [1:0] resp);
    logic done;
    bus_req[p].ar_addr  = {idx[3:0], 2'b00};
    bus_req[p].ar_valid = 1'b1;
    bus_req[p].r_ready  = random_ready();
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = bus_rsp[p].ar_ready;
      @(posedge clk_i);
      #5;
      bus_req[p].r_ready = random_ready();
    end
    bus_req[p].ar_valid = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = bus_rsp[p].r_valid && bus_req[p].r_ready;
      data = bus_rsp[p].r_data;
      resp = bus_rsp[p].r_resp;
      @(posedge clk_i);
      #5;
      bus_req[p].r_ready = random_ready();
    end
    bus_req[p].r_ready = 1'b0;
  endtask

  task automatic write_reg(input int p, input int idx, input logic [31:0] data);
    logic [1:0] exp_resp, got_resp;
    model_write(p, idx, data, exp_resp);
    bus_write(p, idx, data, got_resp);
    compare_value($sformatf("port%0d bresp off%0d", p, idx), got_resp, exp_resp);
  endtask

  task automatic read_reg(input int p, input int idx);
    logic [31:0] exp_data, got_data;
    logic [1:0]  exp_resp, got_resp;
    model_read(p, idx, exp_data, exp_resp);
    bus_read(p, idx, got_data, got_resp);
    compare_value($sformatf("port%0d rdata off%0d", p, idx), got_data, exp_data);
    compare_value($sformatf("port%0d rresp off%0d", p, idx), got_resp, exp_resp);
  endtask

  // give the status bits two edges to settle before sampling the irq level
  task automatic check_irq();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    compare_value("irq_o[0]", irq[0], model_irq(0));
    compare_value("irq_o[1]", irq[1], model_irq(1));
    @(posedge clk_i);
    #5;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s finished with %0d errors", tests, name, errors - errs_at_start);
    errs_at_start = errors;
  endtask

  //------------------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------------------
  initial begin
    void'($urandom(4509));
    rst_i   = 1'b1;
    bus_req = '0;
    errors = 0;
    checks = 0;
    tests  = 0;
    errs_at_start = 0;
    for (int p = 0; p < 2; p++) begin
      fifo_m[p].delete();
      err_m[p]   = '0;
      wthr_m[p]  = 0;
      rthr_m[p]  = 0;
      irqs_m[p]  = '0;
      irqen_m[p] = '0;
    end
    repeat (10) @(posedge clk_i);
    #5;
    rst_i = 1'b0;

    for (int p = 0; p < 2; p++) begin
      for (int r = 0; r < 8; r++) begin
        if (r != 1) read_reg(p, r);  // MBOXR would pop
      end
    end
    check_irq();
    finish_test("reset values");

    for (int k = 0; k < NumWords; k++) begin
      side = $urandom_range(0, 1);
      if ($urandom_range(0, 2) != 0 && fifo_m[side].size() < Depth) begin
        write_reg(side, 0, $urandom());
      end else begin
        read_reg(1 - side, 1);
      end
    end
    for (int p = 0; p < 2; p++) begin
      while (fifo_m[1 - p].size() > 0) read_reg(p, 1);
      read_reg(p, 1);  // empty read
      read_reg(p, 3);  // read-empty flag
      read_reg(p, 3);  // cleared
    end
    finish_test("data path");

    side = $urandom_range(0, 1);
    for (int k = 0; k <= Depth; k++) write_reg(side, 0, $urandom());
    read_reg(side, 2);
    read_reg(side, 3);
    read_reg(side, 6);
    for (int k = 0; k < Depth; k++) read_reg(1 - side, 1);
    finish_test("overflow");

    for (int k = 0; k < NumThrRounds; k++) begin
      side = $urandom_range(0, 1);
      write_reg(side, 6, 7);
      write_reg(1 - side, 6, 7);
      write_reg(side, 4, $urandom_range(0, 15));
      read_reg(side, 4);
      write_reg(1 - side, 5, $urandom_range(0, 15));
      read_reg(1 - side, 5);
      write_reg(side, 7, 1);      // wr threshold irq
      write_reg(1 - side, 7, 2);  // rd threshold irq
      read_reg(side, 7);
      check_irq();
      cnt = wthr_m[side] + 1;     // one past the threshold
      for (int n = 0; n < cnt; n++) write_reg(side, 0, $urandom());
      check_irq();
      read_reg(side, 8);          // wr pending
      read_reg(1 - side, 8);
      for (int n = 0; n < cnt; n++) read_reg(1 - side, 1);
      write_reg(side, 6, 1);
      write_reg(1 - side, 6, 7);
      check_irq();
      read_reg(side, 6);
      write_reg(side, 7, 0);
      write_reg(1 - side, 7, 0);
    end
    finish_test("irq thresholds");

    for (int k = 0; k < 2; k++) begin
      side = $urandom_range(0, 1);
      cnt  = $urandom_range(1, Depth);
      for (int n = 0; n < cnt; n++) write_reg(side, 0, $urandom());
      read_reg(1 - side, 2);
      if (k == 0) begin
        write_reg(side, 9, 1);      // flush from the writer
      end else begin
        write_reg(1 - side, 9, 2);  // flush from the reader
      end
      read_reg(1 - side, 2);
      read_reg(1 - side, 1);
      read_reg(1 - side, 3);
    end
    finish_test("flush");

    for (int k = 0; k < NumRandom; k++) begin
      side = $urandom_range(0, 1);
      sel  = $urandom_range(0, 5);
      if (sel == 0) begin
        write_reg(side, $urandom_range(10, 15), $urandom());
      end else if (sel == 1) begin
        read_reg(side, $urandom_range(10, 15));
      end else begin
        write_reg(side, (sel == 5) ? 8 : sel - 1, $urandom());  // MBOXR to ERROR and IRQP
      end
    end
    for (int p = 0; p < 2; p++) begin
      for (int r = 2; r < 9; r++) read_reg(p, r);
    end
    finish_test("illegal accesses");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog at about ten times the expected run length
  initial begin
    #(PlannedAccesses * 40 * ClkPeriod);
    $display("watchdog expired after %0d cycles, a bus access never completed",
             PlannedAccesses * 40);
    $display("Something failed");
    $finish;
  end

endmodule

// File: lite_mailbox.f
+incdir+.
mbox_bus_pkg.sv
mbox_reg_pkg.sv
mbox_fifo.sv
mbox_resp_stage.sv
mbox_port.sv
lite_mailbox.sv
tb_lite_mailbox.sv
